// File: Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_decode_pkg.sv
      - logic/instr_decoder.sv
      - logic/imm_gen.sv
      - logic/regfile.sv
      - logic/id_stage_ctrl.sv
      - logic/id_ex_reg.sv
      - logic/id_stage_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/id_stage_tb.sv

// File: dv/id_stage_tb.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module id_stage_tb;

   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 8;
   localparam int MAX_ENTRIES    = 16;
   localparam int FLUSH_IDX      = 6;    // Store first shown under a taken branch
   localparam int HOLD_CYCLES    = 12;   // Execute holds its credits at first
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + HOLD_CYCLES + MAX_ENTRIES * 20 + 20;

   logic                      clk_i;
   logic                      rst_n_i;
   logic                      instr_valid_i;
   logic [31:0]               instr_i;
   logic [`XLEN_BITS-1:0]     pc_i;
   logic                      flush_i;
   logic                      credit_return_i;
   logic                      wb_en_i;
   logic [`REG_ADDR_BITS-1:0] wb_rd_i;
   logic [`XLEN_BITS-1:0]     wb_data_i;
   logic                      instr_accept_o;
   logic                      ex_valid_o;
   logic [`XLEN_BITS-1:0]     pc_o;
   logic [`XLEN_BITS-1:0]     rs1_val_o;
   logic [`XLEN_BITS-1:0]     rs2_val_o;
   logic [`XLEN_BITS-1:0]     imm_o;
   rv_decode_pkg::alu_op_e    alu_op_o;
   logic                      op1_pc_o;
   logic                      op2_imm_o;
   rv_decode_pkg::wb_sel_e    wb_sel_o;
   logic [`REG_ADDR_BITS-1:0] rd_o;
   logic                      is_load_o;
   logic                      is_store_o;
   logic                      is_branch_o;
   logic                      is_jump_o;
   logic                      illegal_o;
   logic [2:0]                funct3_o;

   // Stimulus table, flags are {op1_pc, op2_imm, load, store, branch, jump, illegal}
   logic [31:0]               tbl_instr [MAX_ENTRIES];
   rv_decode_pkg::alu_op_e    tbl_alu   [MAX_ENTRIES];
   logic [`XLEN_BITS-1:0]     tbl_imm   [MAX_ENTRIES];
   rv_decode_pkg::wb_sel_e    tbl_wb    [MAX_ENTRIES];
   logic [6:0]                tbl_flags [MAX_ENTRIES];
   logic [`REG_ADDR_BITS-1:0] tbl_rd    [MAX_ENTRIES];
   int                        num_entries;

   logic [`XLEN_BITS-1:0]     model_regs [32];
   logic [`XLEN_BITS-1:0]     exp_rs1;
   logic [`XLEN_BITS-1:0]     exp_rs2;
   int                        exec_q [$];   // Items held by execute
   int                        model_credits;
   logic [31:0]               rng_state;
   int                        cur_idx;      // Entry shown to the stage
   int                        prev_idx;
   logic                      prev_acc;
   logic                      taken;        // Accept expected at the coming edge
   logic                      flushed;
   logic                      load_hazard;
   logic                      exp_accept;
   int                        issue_count;
   int                        hazard_stalls;
   int                        credit_stalls;
   int                        cycle_count;

   id_stage_top dut0 (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Register value seen in the accept cycle, same-cycle writeback included
   function automatic logic [`XLEN_BITS-1:0] model_read(input logic [`REG_ADDR_BITS-1:0] addr);
      return (addr == '0) ? '0 :
             (wb_en_i && (wb_rd_i == addr)) ? wb_data_i : model_regs[addr];
   endfunction

   function automatic logic load_use(input int ex_idx, input int id_idx);
      logic [`REG_ADDR_BITS-1:0] rd;
      rd = tbl_rd[ex_idx];
      return tbl_flags[ex_idx][4] && (rd != '0) &&
             ((rd == tbl_instr[id_idx][19:15]) || (rd == tbl_instr[id_idx][24:20]));
   endfunction

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   task automatic add_entry(input logic [31:0] instr, input rv_decode_pkg::alu_op_e alu,
                            input logic [31:0] imm, input rv_decode_pkg::wb_sel_e wb,
                            input logic [6:0] flags, input logic [4:0] rd);
      tbl_instr[num_entries] = instr;
      tbl_alu[num_entries]   = alu;
      tbl_imm[num_entries]   = imm;
      tbl_wb[num_entries]    = wb;
      tbl_flags[num_entries] = flags;
      tbl_rd[num_entries]    = rd;
      num_entries++;
   endtask

   task automatic check_entry(input int idx);
      string tag;
      tag = $sformatf("entry %0d ", idx);
      check_equal(pc_o, 32'h100 + 4 * idx, {tag, "pc_o"});
      check_equal(alu_op_o, tbl_alu[idx], {tag, "alu_op_o"});
      check_equal(imm_o, tbl_imm[idx], {tag, "imm_o"});
      check_equal(wb_sel_o, tbl_wb[idx], {tag, "wb_sel_o"});
      check_equal({op1_pc_o, op2_imm_o, is_load_o, is_store_o, is_branch_o, is_jump_o,
                   illegal_o}, tbl_flags[idx], {tag, "control flags"});
      check_equal(rd_o, tbl_rd[idx], {tag, "rd_o"});
      check_equal(funct3_o, tbl_instr[idx][14:12], {tag, "funct3_o"});
      check_equal(rs1_val_o, exp_rs1, {tag, "rs1_val_o"});
      check_equal(rs2_val_o, exp_rs2, {tag, "rs2_val_o"});
   endtask

   task automatic build_table();
      add_entry(32'hFFB10093, rv_decode_pkg::ALU_ADD, 32'hFFFFFFFB,   // addi x1, x2, -5
                rv_decode_pkg::WB_ALU, 7'b0100000, 5'd1);
      add_entry(32'h402081B3, rv_decode_pkg::ALU_SUB, 32'h0,          // sub x3, x1, x2
                rv_decode_pkg::WB_ALU, 7'b0000000, 5'd3);
      add_entry(32'h0081A203, rv_decode_pkg::ALU_ADD, 32'h8,          // lw x4, 8(x3)
                rv_decode_pkg::WB_MEM, 7'b0110000, 5'd4);
      add_entry(32'h001202B3, rv_decode_pkg::ALU_ADD, 32'h0,          // add x5, x4, x1
                rv_decode_pkg::WB_ALU, 7'b0000000, 5'd5);
      add_entry(32'h0003A303, rv_decode_pkg::ALU_ADD, 32'h0,          // lw x6, 0(x7)
                rv_decode_pkg::WB_MEM, 7'b0110000, 5'd6);
      add_entry(32'h0F02C113, rv_decode_pkg::ALU_XOR, 32'hF0,         // xori x2, x5, 0xf0
                rv_decode_pkg::WB_ALU, 7'b0100000, 5'd2);
      add_entry(32'hFE61AE23, rv_decode_pkg::ALU_ADD, 32'hFFFFFFFC,   // sw x6, -4(x3)
                rv_decode_pkg::WB_ALU, 7'b0101000, 5'd0);
      add_entry(32'hFE2088E3, rv_decode_pkg::ALU_SUB, 32'hFFFFFFF0,   // beq x1, x2, -16
                rv_decode_pkg::WB_ALU, 7'b0000100, 5'd0);
      add_entry(32'h001000EF, rv_decode_pkg::ALU_ADD, 32'h800,        // jal x1, +2048
                rv_decode_pkg::WB_PC4, 7'b1100010, 5'd1);
      add_entry(32'h00C08067, rv_decode_pkg::ALU_ADD, 32'hC,          // jalr x0, 12(x1)
                rv_decode_pkg::WB_PC4, 7'b0100010, 5'd0);
      add_entry(32'hABCDE3B7, rv_decode_pkg::ALU_PASS_B, 32'hABCDE000,   // lui x7
                rv_decode_pkg::WB_ALU, 7'b0100000, 5'd7);
      add_entry(32'h80001197, rv_decode_pkg::ALU_ADD, 32'h80001000,   // auipc x3
                rv_decode_pkg::WB_ALU, 7'b1100000, 5'd3);
      add_entry(32'h4032D213, rv_decode_pkg::ALU_SRA, 32'h403,        // srai x4, x5, 3
                rv_decode_pkg::WB_ALU, 7'b0100000, 5'd4);
      add_entry(32'h00402283, rv_decode_pkg::ALU_ADD, 32'h4,          // lw x5, 4(x0)
                rv_decode_pkg::WB_MEM, 7'b0110000, 5'd5);
      add_entry(32'h00503333, rv_decode_pkg::ALU_SLTU, 32'h0,         // sltu x6, x0, x5
                rv_decode_pkg::WB_ALU, 7'b0000000, 5'd6);
      add_entry(32'h000002FB, rv_decode_pkg::ALU_ADD, 32'h0,          // Unknown opcode
                rv_decode_pkg::WB_ALU, 7'b0000001, 5'd0);
   endtask

   ////////////////////////////////////////
   // Writeback and execute stand-ins
   ////////////////////////////////////////
   always @(posedge clk_i) begin
      if (rst_n_i) begin
         if (wb_en_i && (wb_rd_i != '0)) begin
            model_regs[wb_rd_i] = wb_data_i;   // Same write the regfile takes now
         end
         rng_state = lcg_next(rng_state);
         wb_en_i <= rng_state[17] | rng_state[19];
         wb_rd_i <= {2'b00, rng_state[25:23]};   // x0 to x7 only
         rng_state = lcg_next(rng_state);
         wb_data_i <= rng_state;
         rng_state = lcg_next(rng_state);
         credit_return_i <= 1'b0;
         if ((cycle_count >= HOLD_CYCLES) && (exec_q.size() > 0) &&
             (rng_state[20:19] != 2'b00)) begin
            void'(exec_q.pop_front());
            credit_return_i <= 1'b1;
         end
         cycle_count++;
      end
   end

   // Outputs and the accept decision are stable at the falling edge
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         check_equal(ex_valid_o, prev_acc, "ex_valid_o one clock after accept");
         if (ex_valid_o) begin
            check_entry(prev_idx);
            check_equal(exec_q.size() < `EX_CREDITS, 1'b1, "execute queue overflow");
            exec_q.push_back(prev_idx);
            issue_count++;
         end
         load_hazard = instr_valid_i && prev_acc && load_use(prev_idx, cur_idx);
         if (load_hazard) begin
            hazard_stalls++;
         end
         if (instr_valid_i && (model_credits == 0)) begin
            credit_stalls++;
         end
         exp_accept = instr_valid_i && !flush_i && !load_hazard && (model_credits > 0);
         check_equal(instr_accept_o, exp_accept, "instr_accept_o");
         if (exp_accept) begin
            exp_rs1 = model_read(tbl_instr[cur_idx][19:15]);
            exp_rs2 = model_read(tbl_instr[cur_idx][24:20]);
            model_credits--;
         end
         if (credit_return_i) begin
            model_credits++;
         end
         taken    = exp_accept;
         prev_acc = exp_accept;
         prev_idx = cur_idx;
      end
   end

   initial begin
      clk_i           = 1'b0;
      rst_n_i         = 1'b0;
      instr_valid_i   = 1'b0;
      instr_i         = '0;
      pc_i            = '0;
      flush_i         = 1'b0;
      credit_return_i = 1'b0;
      wb_en_i         = 1'b0;
      wb_rd_i         = '0;
      wb_data_i       = '0;
      rng_state       = 32'h7714;
      model_credits   = `EX_CREDITS;
      cur_idx         = 0;
      prev_idx        = 0;
      prev_acc        = 1'b0;
      taken           = 1'b0;
      flushed         = 1'b0;
      num_entries     = 0;
      issue_count     = 0;
      hazard_stalls   = 0;
      credit_stalls   = 0;
      cycle_count     = 0;
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      build_table();
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_n_i <= 1'b1;
      while (cur_idx < num_entries) begin
         instr_valid_i <= 1'b1;
         instr_i       <= tbl_instr[cur_idx];
         pc_i          <= 32'h100 + 4 * cur_idx;
         // Taken branch only where a credit is free
         flush_i       <= (cur_idx == FLUSH_IDX) && !flushed && (model_credits > 0);
         flushed = flushed || ((cur_idx == FLUSH_IDX) && (model_credits > 0));
         @(posedge clk_i);
         if (taken) begin
            cur_idx++;   // Fetch moves on only after a handshake
         end
      end
      instr_valid_i <= 1'b0;
      flush_i       <= 1'b0;
      repeat (3) @(posedge clk_i);   // Last item shows one clock after its accept
      check_equal(issue_count, num_entries, "issued item count");
      check_equal(hazard_stalls > 0, 1'b1, "load-use stall seen");
      check_equal(credit_stalls > 0, 1'b1, "stall on empty credit count seen");
      $display("Verification passed");
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: the stage did not issue the whole table in time");
      $display("Verification failed");
      $fatal(1);
   end

endmodule

// File: filelist.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/instr_decoder.sv
logic/imm_gen.sv
logic/regfile.sv
logic/id_stage_ctrl.sv
logic/id_ex_reg.sv
logic/id_stage_top.sv
dv/id_stage_tb.sv

// File: logic/id_ex_reg.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module id_ex_reg (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      issue_i,
   input  logic                      bubble_i,
   input  logic [`XLEN_BITS-1:0]     pc_i,
   input  logic [`XLEN_BITS-1:0]     rs1_val_i,
   input  logic [`XLEN_BITS-1:0]     rs2_val_i,
   input  logic [`XLEN_BITS-1:0]     imm_i,
   input  rv_decode_pkg::alu_op_e    alu_op_i,
   input  logic                      op1_pc_i,
   input  logic                      op2_imm_i,
   input  rv_decode_pkg::wb_sel_e    wb_sel_i,
   input  logic                      reg_wr_i,
   input  logic                      is_load_i,
   input  logic                      is_store_i,
   input  logic                      is_branch_i,
   input  logic                      is_jump_i,
   input  logic                      illegal_i,
   input  logic [`REG_ADDR_BITS-1:0] rd_addr_i,
   input  logic [2:0]                funct3_i,
   output logic                      ex_valid_o,
   output logic [`XLEN_BITS-1:0]     pc_o,
   output logic [`XLEN_BITS-1:0]     rs1_val_o,
   output logic [`XLEN_BITS-1:0]     rs2_val_o,
   output logic [`XLEN_BITS-1:0]     imm_o,
   output rv_decode_pkg::alu_op_e    alu_op_o,
   output logic                      op1_pc_o,
   output logic                      op2_imm_o,
   output rv_decode_pkg::wb_sel_e    wb_sel_o,
   output logic [`REG_ADDR_BITS-1:0] rd_o,
   output logic                      is_load_o,
   output logic                      is_store_o,
   output logic                      is_branch_o,
   output logic                      is_jump_o,
   output logic                      illegal_o,
   output logic [2:0]                funct3_o
);

   ////////////////////////////////////////
   // Valid and control fields
   ////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || bubble_i) begin
         ex_valid_o  <= 1'b0;
         alu_op_o    <= rv_decode_pkg::ALU_ADD;
         op1_pc_o    <= 1'b0;
         op2_imm_o   <= 1'b0;
         wb_sel_o    <= rv_decode_pkg::WB_ALU;
         rd_o        <= '0;
         is_load_o   <= 1'b0;
         is_store_o  <= 1'b0;
         is_branch_o <= 1'b0;
         is_jump_o   <= 1'b0;
         illegal_o   <= 1'b0;
      end else if (issue_i) begin
         ex_valid_o  <= 1'b1;
         alu_op_o    <= alu_op_i;
         op1_pc_o    <= op1_pc_i;
         op2_imm_o   <= op2_imm_i;
         wb_sel_o    <= wb_sel_i;
         rd_o        <= reg_wr_i ? rd_addr_i : '0;   // rd 0 means no write
         is_load_o   <= is_load_i;
         is_store_o  <= is_store_i;
         is_branch_o <= is_branch_i;
         is_jump_o   <= is_jump_i;
         illegal_o   <= illegal_i;
      end else begin
         ex_valid_o <= 1'b0;   // Out of credits, hold fields but stop issuing
      end
   end

   // Operand payload
   always_ff @(posedge clk_i) begin
      if (issue_i) begin
         pc_o      <= pc_i;
         rs1_val_o <= rs1_val_i;
         rs2_val_o <= rs2_val_i;
         imm_o     <= imm_i;
         funct3_o  <= funct3_i;
      end
   end

endmodule

// File: logic/id_stage_ctrl.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module id_stage_ctrl (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      instr_valid_i,
   input  logic                      flush_i,
   input  logic                      credit_return_i,
   input  logic [`REG_ADDR_BITS-1:0] rs1_addr_i,
   input  logic [`REG_ADDR_BITS-1:0] rs2_addr_i,
   input  logic                      ex_is_load_i,
   input  logic                      ex_valid_i,
   input  logic [`REG_ADDR_BITS-1:0] ex_rd_i,
   output logic                      instr_accept_o,
   output logic                      issue_o,
   output logic                      bubble_o
);

   logic [`CREDIT_BITS-1:0] credits_q;
   logic                    has_credit;
   logic                    hazard;

   assign has_credit = (credits_q != '0);

   // Load in EX whose result the decoding instruction needs
   assign hazard = ex_valid_i && ex_is_load_i && (ex_rd_i != '0) &&
                   ((ex_rd_i == rs1_addr_i) || (ex_rd_i == rs2_addr_i));

   assign instr_accept_o = instr_valid_i && !flush_i && !hazard && has_credit;
   assign issue_o        = instr_accept_o;

   // Idle with credit gives a bubble, without credit ID/EX only drops valid
   assign bubble_o = !issue_o && has_credit;

   ////////////////////////////////////////
   // Credit counter toward execute
   ////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         credits_q <= `CREDIT_BITS'(`EX_CREDITS);
      end else begin
         case ({issue_o, credit_return_i})
            2'b10:   credits_q <= credits_q - 1'b1;
            2'b01:   credits_q <= credits_q + 1'b1;
            default: credits_q <= credits_q;   // None, or issue and return together
         endcase
      end
   end

   // Execute never returns more credits than it was given
   a_credit_range: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      credits_q <= `CREDIT_BITS'(`EX_CREDITS)
   ) else $error("credit counter above execute queue depth");

   // A return needs an item in flight
   a_return_needs_issue: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      credit_return_i |-> (credits_q < `CREDIT_BITS'(`EX_CREDITS))
   ) else $error("credit returned while the counter was full");

endmodule

// File: logic/id_stage_top.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module id_stage_top (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      instr_valid_i,
   input  logic [31:0]               instr_i,
   input  logic [`XLEN_BITS-1:0]     pc_i,
   input  logic                      flush_i,
   input  logic                      credit_return_i,
   input  logic                      wb_en_i,
   input  logic [`REG_ADDR_BITS-1:0] wb_rd_i,
   input  logic [`XLEN_BITS-1:0]     wb_data_i,
   output logic                      instr_accept_o,
   output logic                      ex_valid_o,
   output logic [`XLEN_BITS-1:0]     pc_o,
   output logic [`XLEN_BITS-1:0]     rs1_val_o,
   output logic [`XLEN_BITS-1:0]     rs2_val_o,
   output logic [`XLEN_BITS-1:0]     imm_o,
   output rv_decode_pkg::alu_op_e    alu_op_o,
   output logic                      op1_pc_o,
   output logic                      op2_imm_o,
   output rv_decode_pkg::wb_sel_e    wb_sel_o,
   output logic [`REG_ADDR_BITS-1:0] rd_o,
   output logic                      is_load_o,
   output logic                      is_store_o,
   output logic                      is_branch_o,
   output logic                      is_jump_o,
   output logic                      illegal_o,
   output logic [2:0]                funct3_o
);

   // Instruction fields
   logic [`REG_ADDR_BITS-1:0] rs1_addr;
   logic [`REG_ADDR_BITS-1:0] rs2_addr;
   logic [`REG_ADDR_BITS-1:0] rd_addr;

   assign rs1_addr = instr_i[19:15];
   assign rs2_addr = instr_i[24:20];
   assign rd_addr  = instr_i[11:7];

   // Decoder outputs
   rv_decode_pkg::alu_op_e   dec_alu_op;
   rv_decode_pkg::imm_fmt_e  dec_imm_fmt;
   rv_decode_pkg::wb_sel_e   dec_wb_sel;
   logic                     dec_op1_pc;
   logic                     dec_op2_imm;
   logic                     dec_reg_wr;
   logic                     dec_is_load;
   logic                     dec_is_store;
   logic                     dec_is_branch;
   logic                     dec_is_jump;
   logic                     dec_illegal;

   logic [`XLEN_BITS-1:0] imm;
   logic [`XLEN_BITS-1:0] rs1_val;
   logic [`XLEN_BITS-1:0] rs2_val;
   logic                  issue;
   logic                  bubble;

   instr_decoder u_decoder (
      .instr_i     (instr_i),
      .alu_op_o    (dec_alu_op),
      .imm_fmt_o   (dec_imm_fmt),
      .wb_sel_o    (dec_wb_sel),
      .op1_pc_o    (dec_op1_pc),
      .op2_imm_o   (dec_op2_imm),
      .reg_wr_o    (dec_reg_wr),
      .is_load_o   (dec_is_load),
      .is_store_o  (dec_is_store),
      .is_branch_o (dec_is_branch),
      .is_jump_o   (dec_is_jump),
      .illegal_o   (dec_illegal)
   );

   imm_gen u_imm_gen (
      .instr_i   (instr_i),
      .imm_fmt_i (dec_imm_fmt),
      .imm_o     (imm)
   );

   regfile u_regfile (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_en_i    (wb_en_i),
      .wr_addr_i  (wb_rd_i),
      .wr_data_i  (wb_data_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_data_o (rs1_val),
      .rs2_data_o (rs2_val)
   );

   // Hazard check looks back at what ID/EX holds
   id_stage_ctrl u_ctrl (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .instr_valid_i   (instr_valid_i),
      .flush_i         (flush_i),
      .credit_return_i (credit_return_i),
      .rs1_addr_i      (rs1_addr),
      .rs2_addr_i      (rs2_addr),
      .ex_is_load_i    (is_load_o),
      .ex_valid_i      (ex_valid_o),
      .ex_rd_i         (rd_o),
      .instr_accept_o  (instr_accept_o),
      .issue_o         (issue),
      .bubble_o        (bubble)
   );

   id_ex_reg u_id_ex (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .issue_i     (issue),
      .bubble_i    (bubble),
      .pc_i        (pc_i),
      .rs1_val_i   (rs1_val),
      .rs2_val_i   (rs2_val),
      .imm_i       (imm),
      .alu_op_i    (dec_alu_op),
      .op1_pc_i    (dec_op1_pc),
      .op2_imm_i   (dec_op2_imm),
      .wb_sel_i    (dec_wb_sel),
      .reg_wr_i    (dec_reg_wr),
      .is_load_i   (dec_is_load),
      .is_store_i  (dec_is_store),
      .is_branch_i (dec_is_branch),
      .is_jump_i   (dec_is_jump),
      .illegal_i   (dec_illegal),
      .rd_addr_i   (rd_addr),
      .funct3_i    (instr_i[14:12]),
      .ex_valid_o  (ex_valid_o),
      .pc_o        (pc_o),
      .rs1_val_o   (rs1_val_o),
      .rs2_val_o   (rs2_val_o),
      .imm_o       (imm_o),
      .alu_op_o    (alu_op_o),
      .op1_pc_o    (op1_pc_o),
      .op2_imm_o   (op2_imm_o),
      .wb_sel_o    (wb_sel_o),
      .rd_o        (rd_o),
      .is_load_o   (is_load_o),
      .is_store_o  (is_store_o),
      .is_branch_o (is_branch_o),
      .is_jump_o   (is_jump_o),
      .illegal_o   (illegal_o),
      .funct3_o    (funct3_o)
   );

endmodule

// File: logic/imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module imm_gen (
   input  logic [`XLEN_BITS-1:0]    instr_i,
   input  rv_decode_pkg::imm_fmt_e  imm_fmt_i,
   output logic [`XLEN_BITS-1:0]    imm_o
);

   logic sign;

   assign sign = instr_i[31];   // Sign bit sits at 31 in every format

   always_comb begin
      case (imm_fmt_i)
         rv_decode_pkg::IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
         rv_decode_pkg::IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
         rv_decode_pkg::IMM_B: begin
            imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
         end
         rv_decode_pkg::IMM_U: imm_o = {instr_i[31:12], 12'b0};
         rv_decode_pkg::IMM_J: begin
            imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
         end
         default: imm_o = '0;   // No immediate
      endcase
   end

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
   input  logic [31:0]              instr_i,
   output rv_decode_pkg::alu_op_e   alu_op_o,
   output rv_decode_pkg::imm_fmt_e  imm_fmt_o,
   output rv_decode_pkg::wb_sel_e   wb_sel_o,
   output logic                     op1_pc_o,
   output logic                     op2_imm_o,
   output logic                     reg_wr_o,
   output logic                     is_load_o,
   output logic                     is_store_o,
   output logic                     is_branch_o,
   output logic                     is_jump_o,
   output logic                     illegal_o
);

   rv_decode_pkg::opcode_e opcode;
   logic [2:0]             funct3;
   logic                   funct7_b5;
   logic                   funct7_rsvd;   // funct7 bits other than bit 30
   logic                   bad;

   assign opcode      = rv_decode_pkg::opcode_e'(instr_i[6:2]);
   assign funct3      = instr_i[14:12];
   assign funct7_b5   = instr_i[30];
   assign funct7_rsvd = instr_i[31] | (|instr_i[29:25]);

   // Shared by OP and OP-IMM, alt picks SUB/SRA
   function automatic rv_decode_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                             input logic       alt);
      case (f3)
         3'b000:  return alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
         3'b001:  return rv_decode_pkg::ALU_SLL;
         3'b010:  return rv_decode_pkg::ALU_SLT;
         3'b011:  return rv_decode_pkg::ALU_SLTU;
         3'b100:  return rv_decode_pkg::ALU_XOR;
         3'b101:  return alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
         3'b110:  return rv_decode_pkg::ALU_OR;
         default: return rv_decode_pkg::ALU_AND;
      endcase
   endfunction

   always_comb begin
      alu_op_o    = rv_decode_pkg::ALU_ADD;
      imm_fmt_o   = rv_decode_pkg::IMM_NONE;
      wb_sel_o    = rv_decode_pkg::WB_ALU;
      op1_pc_o    = 1'b0;
      op2_imm_o   = 1'b0;
      reg_wr_o    = 1'b0;
      is_load_o   = 1'b0;
      is_store_o  = 1'b0;
      is_branch_o = 1'b0;
      is_jump_o   = 1'b0;
      bad         = (instr_i[1:0] != 2'b11);   // Compressed space not supported

      case (opcode)
         rv_decode_pkg::OPC_LOAD: begin
            imm_fmt_o = rv_decode_pkg::IMM_I;
            op2_imm_o = 1'b1;   // Address = rs1 + imm
            wb_sel_o  = rv_decode_pkg::WB_MEM;
            reg_wr_o  = 1'b1;
            is_load_o = 1'b1;
            bad       = bad | (funct3 == 3'b011) | (funct3[2:1] == 2'b11);
         end
         rv_decode_pkg::OPC_STORE: begin
            imm_fmt_o  = rv_decode_pkg::IMM_S;
            op2_imm_o  = 1'b1;
            is_store_o = 1'b1;
            bad        = bad | funct3[2] | (funct3[1:0] == 2'b11);
         end
         rv_decode_pkg::OPC_BRANCH: begin
            // Compare on rs1 - rs2, execute adds PC + imm for the target
            imm_fmt_o   = rv_decode_pkg::IMM_B;
            alu_op_o    = rv_decode_pkg::ALU_SUB;
            is_branch_o = 1'b1;
            bad         = bad | (funct3[2:1] == 2'b01);
         end
         rv_decode_pkg::OPC_JAL: begin
            imm_fmt_o = rv_decode_pkg::IMM_J;
            op1_pc_o  = 1'b1;
            op2_imm_o = 1'b1;
            wb_sel_o  = rv_decode_pkg::WB_PC4;
            reg_wr_o  = 1'b1;
            is_jump_o = 1'b1;
         end
         rv_decode_pkg::OPC_JALR: begin
            imm_fmt_o = rv_decode_pkg::IMM_I;
            op2_imm_o = 1'b1;
            wb_sel_o  = rv_decode_pkg::WB_PC4;
            reg_wr_o  = 1'b1;
            is_jump_o = 1'b1;
            bad       = bad | (funct3 != 3'b000);
         end
         rv_decode_pkg::OPC_OP_IMM: begin
            imm_fmt_o = rv_decode_pkg::IMM_I;
            op2_imm_o = 1'b1;
            reg_wr_o  = 1'b1;
            // Bit 30 only means SRAI, for ADDI it is immediate data
            alu_op_o  = alu_from_funct(funct3, (funct3 == 3'b101) & funct7_b5);
            if (funct3 == 3'b001) begin
               bad = bad | funct7_rsvd | funct7_b5;
            end else if (funct3 == 3'b101) begin
               bad = bad | funct7_rsvd;
            end
         end
         rv_decode_pkg::OPC_OP: begin
            reg_wr_o = 1'b1;
            alu_op_o = alu_from_funct(funct3, funct7_b5);
            bad      = bad | funct7_rsvd |
                       (funct7_b5 & (funct3 != 3'b000) & (funct3 != 3'b101));
         end
         rv_decode_pkg::OPC_LUI: begin
            imm_fmt_o = rv_decode_pkg::IMM_U;
            op2_imm_o = 1'b1;
            alu_op_o  = rv_decode_pkg::ALU_PASS_B;
            reg_wr_o  = 1'b1;
         end
         rv_decode_pkg::OPC_AUIPC: begin
            imm_fmt_o = rv_decode_pkg::IMM_U;
            op1_pc_o  = 1'b1;
            op2_imm_o = 1'b1;
            reg_wr_o  = 1'b1;
         end
         default: bad = 1'b1;
      endcase

      // Illegal instructions travel on but change no state
      if (bad) begin
         reg_wr_o   = 1'b0;
         is_load_o  = 1'b0;
         is_store_o = 1'b0;
      end
      illegal_o = bad;
   end

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module regfile (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      wr_en_i,
   input  logic [`REG_ADDR_BITS-1:0] wr_addr_i,
   input  logic [`XLEN_BITS-1:0]     wr_data_i,
   input  logic [`REG_ADDR_BITS-1:0] rs1_addr_i,
   input  logic [`REG_ADDR_BITS-1:0] rs2_addr_i,
   output logic [`XLEN_BITS-1:0]     rs1_data_o,
   output logic [`XLEN_BITS-1:0]     rs2_data_o
);

   localparam int NUM_REGS = 2 ** `REG_ADDR_BITS;

   logic [`XLEN_BITS-1:0] regs [1:NUM_REGS-1];   // x0 has no storage

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i && (wr_addr_i != '0)) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   // One read port, with bypass of a same-cycle writeback
   function automatic logic [`XLEN_BITS-1:0] read_port(input logic [`REG_ADDR_BITS-1:0] addr);
      if (addr == '0) begin
         return '0;
      end
      if (wr_en_i && (addr == wr_addr_i)) begin
         return wr_data_i;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rs1_data_o = read_port(rs1_addr_i);
      rs2_data_o = read_port(rs2_addr_i);
   end

endmodule

// File: logic/rv_decode_consts.svh
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// Datapath width
`define XLEN_BITS 32

// Register file addressing, 32 entries
`define REG_ADDR_BITS 5

// Execute queue depth and credit counter width
`define EX_CREDITS 2
`define CREDIT_BITS 2

`endif

// File: logic/rv_decode_pkg.sv
package rv_decode_pkg;

   ////////////////////////////////////////
   // Major opcodes, instr[6:2]
   ////////////////////////////////////////
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_STORE  = 5'b01000,
      OPC_BRANCH = 5'b11000,
      OPC_JAL    = 5'b11011,
      OPC_JALR   = 5'b11001,
      OPC_OP_IMM = 5'b00100,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_AUIPC  = 5'b00101
   } opcode_e;

   // ALU operations seen by execute
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd2,
      ALU_SLT    = 4'd3,
      ALU_SLTU   = 4'd4,
      ALU_XOR    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_AND    = 4'd9,
      ALU_PASS_B = 4'd10   // LUI, operand B straight through
   } alu_op_e;

   // Immediate formats
   typedef enum logic [2:0] {
      IMM_I    = 3'd0,
      IMM_S    = 3'd1,
      IMM_B    = 3'd2,
      IMM_U    = 3'd3,
      IMM_J    = 3'd4,
      IMM_NONE = 3'd5
   } imm_fmt_e;

   // Writeback source
   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd2   // Link address for JAL/JALR
   } wb_sel_e;

endpackage
